//--- src.f
chip_pkg.sv
reg_bus_if.sv
jtag_mux.sv
jtag_dtm.sv
gpio_ctrl.sv
bus_arbiter.sv
reg_file.sv
chip_top.sv
chip_arb_chk.sv
tb_chip.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; success needs the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_chip -f src.f \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_chip | tee /dev/stderr | grep -q "^NO ERRORS$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tb_chip.sv
// Testbench for chip_top. Drives TMS-framed JTAG commands on the dedicated pads
// and checks pad outputs and register read-back against a register model.

module tb_chip;

  localparam int NumMio = chip_pkg::NumMio;
  localparam int NumIos = chip_pkg::NumIos;
  localparam int FrameW = chip_pkg::FrameW;
  // 12 frames of about 120 cycles plus short waits, with a wide margin
  localparam int TimeoutCycles = 20000;

  logic              clk_i, rst_i;
  logic [7:0]        mio_in, mio_out, mio_oe;
  logic [3:0]        dio_in, dio_out, dio_oe; // dio_in[2:0] carry TDI, TMS, TCK
  logic [31:0]       seed;
  logic [7:0]        model [chip_pkg::NumRegs];
  int                cycles, err_cnt;
  string             name_q [$];
  logic [NumIos-1:0] exp_q [$];
  logic [NumIos-1:0] act_q [$];
  string             chk_name;
  logic [NumIos-1:0] chk_exp, chk_act;

  chip_top dut (
    .clk_i     ( clk_i   ),
    .rst_i     ( rst_i   ),
    .mio_in_i  ( mio_in  ),
    .dio_in_i  ( dio_in  ),
    .mio_out_o ( mio_out ),
    .mio_oe_o  ( mio_oe  ),
    .dio_out_o ( dio_out ),
    .dio_oe_o  ( dio_oe  )
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic rand_byte(output logic [7:0] val);
    seed = lcg_next(seed);
    val  = seed[23:16]; // Upper bits are the better ones
  endtask

  // Pads {oe, out} from register contents, JTAG pads take the overlay
  function automatic logic [2*NumIos-1:0] expect_pads(input logic [7:0] out_lo, oe_lo,
                                                      input logic [7:0] out_hi, oe_hi,
                                                      input logic strap);
    logic [NumIos-1:0] pad_out, pad_oe;
    pad_out = {out_hi[3:0], out_lo};
    pad_oe  = {oe_hi[3:0], oe_lo};
    if (strap) begin
      pad_oe[chip_pkg::TckIdx]  = 1'b0;
      pad_oe[chip_pkg::TmsIdx]  = 1'b0;
      pad_oe[chip_pkg::TdiIdx]  = 1'b0;
      pad_oe[chip_pkg::TdoIdx]  = 1'b1; // Only TDO drives
      pad_out[chip_pkg::TckIdx] = 1'b0;
      pad_out[chip_pkg::TmsIdx] = 1'b0;
      pad_out[chip_pkg::TdiIdx] = 1'b0;
      pad_out[chip_pkg::TdoIdx] = 1'b0; // Serial data, masked by caller
    end
    return {pad_oe, pad_out};
  endfunction

  // Input snapshot as the core sees it
  function automatic logic [NumIos-1:0] expect_snapshot(input logic [7:0] mio,
                                                        input logic [3:0] dio,
                                                        input logic strap);
    logic [NumIos-1:0] pads;
    pads = {dio, mio};
    if (strap) begin
      for (int i = NumMio; i < NumIos; i++) pads[i] = chip_pkg::TieOffValues[i];
    end
    return pads;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers, all called on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic tick(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic expect_val(input string name, input logic [NumIos-1:0] exp_v,
                            input logic [NumIos-1:0] act_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
  endtask

  task automatic check_pads(input logic [2*NumIos-1:0] exp_v, input logic [7:0] mio_mask,
                            input logic [3:0] dio_mask);
    expect_val("mio_out_o", NumIos'(exp_v[7:0] & mio_mask), NumIos'(mio_out & mio_mask));
    expect_val("mio_oe_o", NumIos'(exp_v[19:12] & mio_mask), NumIos'(mio_oe & mio_mask));
    expect_val("dio_out_o", NumIos'(exp_v[11:8] & dio_mask), NumIos'(dio_out & dio_mask));
    expect_val("dio_oe_o", NumIos'(exp_v[23:20]), NumIos'(dio_oe));
  endtask

  // One frame, MSB first, 4 clocks per TCK phase; TDO sampled before each rise
  task automatic jtag_frame(input logic [FrameW-1:0] frame, output logic [FrameW-1:0] tdo_bits);
    dio_in[1] = 1'b1;
    for (int i = 0; i < FrameW; i++) begin
      dio_in[2] = frame[FrameW-1-i];
      dio_in[0] = 1'b0;
      tick(4);
      tdo_bits[i] = dio_out[3];
      dio_in[0] = 1'b1;
      tick(4);
    end
    dio_in[0] = 1'b0;
    tick(4);
    dio_in[1] = 1'b0; // TMS fall issues the access
    tick(12);
  endtask

  task automatic jtag_write(input logic [2:0] addr, input logic [7:0] data);
    logic [FrameW-1:0] bits;
    jtag_frame({1'b1, addr, data}, bits);
    model[addr] = data;
  endtask

  task automatic jtag_read(input logic [2:0] addr, output logic [7:0] data);
    logic [FrameW-1:0] bits;
    jtag_frame({1'b0, addr, 8'h00}, bits);
    jtag_frame({1'b0, chip_pkg::RegOutLo, 8'h00}, bits); // Dummy frame clocks data out
    data = bits[7:0];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    while (name_q.size() > 0) begin
      chk_name = name_q.pop_front();
      chk_exp  = exp_q.pop_front();
      chk_act  = act_q.pop_front();
      assert (chk_act === chk_exp) else begin
        $display("Fail at %0t: %s expected %h, got %h", $time, chk_name, chk_exp, chk_act);
        err_cnt++;
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first mismatch");
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("ERRORS FOUND");
      $fatal(1, "Timeout, test sequence did not finish in %0d cycles", TimeoutCycles);
    end
  end

  initial begin
    logic [7:0]        v0, v1, rd;
    logic [NumIos-1:0] snap;
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    mio_in  = '0;
    dio_in  = '0;
    seed    = 32'h4c7e2ccd;
    cycles  = 0;
    err_cnt = 0;
    for (int i = 0; i < chip_pkg::NumRegs; i++) model[i] = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    tick(4);

    // Reset state, strap low
    check_pads(expect_pads(8'h00, 8'h00, 8'h00, 8'h00, 1'b0), 8'hff, 4'hf);

    // Strap high, write mio out/oe over JTAG
    mio_in[chip_pkg::JtagEnIdx] = 1'b1;
    tick(4);
    rand_byte(v0);
    rand_byte(v1);
    jtag_write(chip_pkg::RegOutLo, v0);
    jtag_write(chip_pkg::RegOeLo, v1);
    tick(20);
    check_pads(expect_pads(model[0], model[1], model[2], model[3], 1'b1), 8'h7f, 4'h7);

    // Read-back on TDO
    jtag_read(chip_pkg::RegOutLo, rd);
    expect_val("tdo RegOutLo", NumIos'(model[0]), NumIos'(rd));
    jtag_read(chip_pkg::RegOeLo, rd);
    expect_val("tdo RegOeLo", NumIos'(model[1]), NumIos'(rd));

    // Input snapshot with tie-offs on the JTAG pads
    rand_byte(v0);
    mio_in    = {1'b1, v0[6:0]};
    dio_in[3] = v0[7];
    tick(20);
    snap = expect_snapshot(mio_in, dio_in, 1'b1);
    jtag_read(chip_pkg::RegInLo, rd);
    expect_val("tdo RegInLo", NumIos'(snap[7:0]), NumIos'(rd));
    jtag_read(chip_pkg::RegInHi, rd);
    expect_val("tdo RegInHi", NumIos'(snap[11:8]), NumIos'(rd));

    // dio registers, then release the overlay
    rand_byte(v0);
    rand_byte(v1);
    jtag_write(chip_pkg::RegOutHi, v0);
    jtag_write(chip_pkg::RegOeHi, v1);
    mio_in[chip_pkg::JtagEnIdx] = 1'b0;
    tick(20);
    check_pads(expect_pads(model[0], model[1], model[2], model[3], 1'b0), 8'hff, 4'hf);

    tick(4);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- chip_arb_chk.sv
// Concurrent checks on the two-master arbiter, bound into bus_arbiter.
// Covers round-robin grants, request hold and read response routing.

module chip_arb_chk (
  input logic                                        clk_i,
  input logic                                        rst_i,
  input logic                                        m0_req_i,
  input logic                                        m0_gnt_i,
  input logic                                        m0_rvalid_i,
  input logic [chip_pkg::AddrW+chip_pkg::DataW:0]    m0_cmd_i, // {we, addr, wdata}
  input logic                                        m1_req_i,
  input logic                                        m1_gnt_i,
  input logic                                        m1_rvalid_i,
  input logic [chip_pkg::AddrW+chip_pkg::DataW:0]    m1_cmd_i
);

  localparam int CmdW = chip_pkg::AddrW + chip_pkg::DataW + 1;

  // Round robin, a master refused in one cycle wins the next, alone
  a_m0_turn: assert property (@(posedge clk_i) disable iff (rst_i)
    m0_req_i && !m0_gnt_i |=> m0_gnt_i && !m1_gnt_i)
    else $error("m0 refused twice in a row or its grant was shared");
  a_m1_turn: assert property (@(posedge clk_i) disable iff (rst_i)
    m1_req_i && !m1_gnt_i |=> m1_gnt_i && !m0_gnt_i)
    else $error("m1 refused twice in a row or its grant was shared");

  // Held requests keep their fields
  a_m0_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    m0_req_i && !m0_gnt_i |=> m0_req_i && $stable(m0_cmd_i))
    else $error("m0 request changed before its grant");
  a_m1_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    m1_req_i && !m1_gnt_i |=> m1_req_i && $stable(m1_cmd_i))
    else $error("m1 request changed before its grant");

  // rvalid one cycle after a granted read of the same master, never otherwise
  a_m0_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    m0_rvalid_i == $past(m0_gnt_i && !m0_cmd_i[CmdW-1]))
    else $error("m0 rvalid out of step with its read grant");
  a_m1_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    m1_rvalid_i == $past(m1_gnt_i && !m1_cmd_i[CmdW-1]))
    else $error("m1 rvalid out of step with its read grant");

endmodule

bind bus_arbiter chip_arb_chk arb_chk (
  .clk_i       ( clk_i                         ),
  .rst_i       ( rst_i                         ),
  .m0_req_i    ( m0.req                        ),
  .m0_gnt_i    ( m0.gnt                        ),
  .m0_rvalid_i ( m0.rvalid                     ),
  .m0_cmd_i    ( {m0.we, m0.addr, m0.wdata}    ),
  .m1_req_i    ( m1.req                        ),
  .m1_gnt_i    ( m1.gnt                        ),
  .m1_rvalid_i ( m1.rvalid                     ),
  .m1_cmd_i    ( {m1.we, m1.addr, m1.wdata}    )
);

//--- chip_top.sv
// Chip-level wrapper: JTAG overlay mux on the pads, JTAG transport and
// GPIO controller sharing the register file through the arbiter.

module chip_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [chip_pkg::NumMio-1:0] mio_in_i,
  input  logic [chip_pkg::NumDio-1:0] dio_in_i,
  output logic [chip_pkg::NumMio-1:0] mio_out_o,
  output logic [chip_pkg::NumMio-1:0] mio_oe_o,
  output logic [chip_pkg::NumDio-1:0] dio_out_o,
  output logic [chip_pkg::NumDio-1:0] dio_oe_o
);

  localparam int NumMio = chip_pkg::NumMio;
  localparam int NumIos = chip_pkg::NumIos;

  logic [NumIos-1:0] out_padring, oe_padring;
  logic [NumIos-1:0] out_core, oe_core, in_core;
  logic              jtag_tck, jtag_tms, jtag_tdi, jtag_tdo;

  ////////////////////////////////////////////////////////////////////////////
  // Pads and JTAG overlay
  ////////////////////////////////////////////////////////////////////////////

  assign mio_out_o = out_padring[NumMio-1:0];
  assign mio_oe_o  = oe_padring[NumMio-1:0];
  assign dio_out_o = out_padring[NumIos-1:NumMio];
  assign dio_oe_o  = oe_padring[NumIos-1:NumMio];

  jtag_mux #(
    .NumIOs       ( NumIos                 ),
    .JtagEnIdx    ( chip_pkg::JtagEnIdx    ),
    .TckIdx       ( chip_pkg::TckIdx       ),
    .TmsIdx       ( chip_pkg::TmsIdx       ),
    .TdiIdx       ( chip_pkg::TdiIdx       ),
    .TdoIdx       ( chip_pkg::TdoIdx       ),
    .TieOffValues ( chip_pkg::TieOffValues )
  ) jtag_mux (
    .in_padring_i  ( {dio_in_i, mio_in_i} ),
    .out_padring_o ( out_padring          ),
    .oe_padring_o  ( oe_padring           ),
    .out_core_i    ( out_core             ),
    .oe_core_i     ( oe_core              ),
    .in_core_o     ( in_core              ),
    .jtag_tck_o    ( jtag_tck             ),
    .jtag_tms_o    ( jtag_tms             ),
    .jtag_tdi_o    ( jtag_tdi             ),
    .jtag_tdo_i    ( jtag_tdo             )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bus masters, arbiter and register file
  ////////////////////////////////////////////////////////////////////////////

  reg_bus_if #(.AddrW(chip_pkg::AddrW), .DataW(chip_pkg::DataW)) bus_dtm ();
  reg_bus_if #(.AddrW(chip_pkg::AddrW), .DataW(chip_pkg::DataW)) bus_gpio ();
  reg_bus_if #(.AddrW(chip_pkg::AddrW), .DataW(chip_pkg::DataW)) bus_mem ();

  jtag_dtm jtag_dtm (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .jtag_tck_i ( jtag_tck ),
    .jtag_tms_i ( jtag_tms ),
    .jtag_tdi_i ( jtag_tdi ),
    .jtag_tdo_o ( jtag_tdo ),
    .bus        ( bus_dtm  )
  );

  gpio_ctrl #(
    .NumMio ( chip_pkg::NumMio ),
    .NumDio ( chip_pkg::NumDio )
  ) gpio_ctrl (
    .clk_i     ( clk_i    ),
    .rst_i     ( rst_i    ),
    .pad_in_i  ( in_core  ),
    .pad_out_o ( out_core ),
    .pad_oe_o  ( oe_core  ),
    .bus       ( bus_gpio )
  );

  bus_arbiter bus_arbiter (
    .clk_i ( clk_i    ),
    .rst_i ( rst_i    ),
    .m0    ( bus_dtm  ),
    .m1    ( bus_gpio ),
    .mem   ( bus_mem  )
  );

  reg_file #(
    .NumRegs ( chip_pkg::NumRegs )
  ) reg_file (
    .clk_i ( clk_i   ),
    .rst_i ( rst_i   ),
    .bus   ( bus_mem )
  );

endmodule

//--- reg_file.sv
// Small single-port register file. Always accepts, writes in the gnt
// cycle and returns read data one cycle later.

module reg_file #(
  parameter int NumRegs = 6
) (
  input  logic     clk_i,
  input  logic     rst_i,
  reg_bus_if.slave bus
);

  logic [chip_pkg::DataW-1:0] regs_q [NumRegs];
  logic                       addr_ok;

  assign addr_ok = int'(bus.addr) < NumRegs;
  assign bus.gnt = bus.req; // No wait states

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NumRegs; i++) regs_q[i] <= '0;
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req & ~bus.we;
      if (bus.req && bus.we && addr_ok) regs_q[bus.addr] <= bus.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) bus.rdata <= addr_ok ? regs_q[bus.addr] : '0;
  end

endmodule

//--- bus_arbiter.sv
// Two-master round-robin arbiter onto the single register file port.
// m0 is the JTAG transport, m1 the GPIO controller.

module bus_arbiter (
  input  logic      clk_i,
  input  logic      rst_i,
  reg_bus_if.slave  m0,
  reg_bus_if.slave  m1,
  reg_bus_if.master mem
);

  logic last_m1_q;  // Last grant went to m1
  logic owner_m1_q; // Read in flight belongs to m1
  logic sel_m1;

  // m1 wins when alone, or when both ask and m0 had the last turn
  assign sel_m1 = m1.req & (~m0.req | ~last_m1_q);

  assign mem.req   = m0.req | m1.req;
  assign mem.we    = sel_m1 ? m1.we    : m0.we;
  assign mem.addr  = sel_m1 ? m1.addr  : m0.addr;
  assign mem.wdata = sel_m1 ? m1.wdata : m0.wdata;

  assign m0.gnt = mem.gnt & ~sel_m1;
  assign m1.gnt = mem.gnt & sel_m1;

  assign m0.rdata  = mem.rdata;
  assign m1.rdata  = mem.rdata;
  assign m0.rvalid = mem.rvalid & ~owner_m1_q;
  assign m1.rvalid = mem.rvalid & owner_m1_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_m1_q  <= 1'b0;
      owner_m1_q <= 1'b0;
    end else if (mem.gnt) begin
      last_m1_q <= sel_m1;
      if (!mem.we) owner_m1_q <= sel_m1; // Response comes next cycle
    end
  end

endmodule

//--- gpio_ctrl.sv
// GPIO controller: keeps pad out/oe shadows refreshed from the register
// file and writes input snapshots back whenever the pad inputs change.

module gpio_ctrl #(
  parameter int NumMio = 8,
  parameter int NumDio = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [NumMio+NumDio-1:0] pad_in_i,
  output logic [NumMio+NumDio-1:0] pad_out_o,
  output logic [NumMio+NumDio-1:0] pad_oe_o,
  reg_bus_if.master                bus
);

  localparam int NumIos = NumMio + NumDio;
  localparam int AddrW  = chip_pkg::AddrW;
  localparam int DataW  = chip_pkg::DataW;

  logic [NumIos-1:0] in_q1, in_q2, snap_q;
  logic [NumIos-1:0] out_q, oe_q;
  logic              req_q, we_q, wait_rv_q, hi_pend_q;
  logic [AddrW-1:0]  addr_q;
  logic [DataW-1:0]  wdata_q;
  logic [1:0]        rd_idx_q; // Walks RegOutLo..RegOeHi

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_q1     <= '0;
      in_q2     <= '0;
      snap_q    <= '0;
      out_q     <= '0;
      oe_q      <= '0;
      req_q     <= 1'b0;
      wait_rv_q <= 1'b0;
      hi_pend_q <= 1'b0;
      rd_idx_q  <= '0;
    end else begin
      in_q1 <= pad_in_i;
      in_q2 <= in_q1;

      if (req_q) begin
        if (bus.gnt) begin
          req_q     <= 1'b0;
          wait_rv_q <= ~we_q;
        end
      end else if (wait_rv_q) begin
        if (bus.rvalid) begin
          wait_rv_q <= 1'b0;
          rd_idx_q  <= rd_idx_q + 2'd1;
          case (addr_q)
            chip_pkg::RegOutLo: out_q[NumMio-1:0]      <= bus.rdata[NumMio-1:0];
            chip_pkg::RegOeLo:  oe_q[NumMio-1:0]       <= bus.rdata[NumMio-1:0];
            chip_pkg::RegOutHi: out_q[NumIos-1:NumMio] <= bus.rdata[NumDio-1:0];
            chip_pkg::RegOeHi:  oe_q[NumIos-1:NumMio]  <= bus.rdata[NumDio-1:0];
            default: ;
          endcase
        end
      end else if (hi_pend_q) begin
        // Second half of a snapshot
        req_q     <= 1'b1;
        we_q      <= 1'b1;
        addr_q    <= chip_pkg::RegInHi;
        wdata_q   <= DataW'(snap_q[NumIos-1:NumMio]);
        hi_pend_q <= 1'b0;
      end else if (in_q2 != snap_q) begin
        req_q     <= 1'b1;
        we_q      <= 1'b1;
        addr_q    <= chip_pkg::RegInLo;
        wdata_q   <= DataW'(in_q2[NumMio-1:0]);
        snap_q    <= in_q2;
        hi_pend_q <= 1'b1;
      end else begin
        req_q  <= 1'b1; // Next refresh read
        we_q   <= 1'b0;
        addr_q <= chip_pkg::RegOutLo + {1'b0, rd_idx_q};
      end
    end
  end

  assign bus.req   = req_q;
  assign bus.we    = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

  assign pad_out_o = out_q;
  assign pad_oe_o  = oe_q;

endmodule

//--- jtag_dtm.sv
// Debug transport: oversamples the JTAG pins, collects TMS-framed commands
// and turns each frame into one register bus access. Read data goes out on TDO.

module jtag_dtm (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      jtag_tck_i,
  input  logic      jtag_tms_i,
  input  logic      jtag_tdi_i,
  output logic      jtag_tdo_o,
  reg_bus_if.master bus
);

  localparam int FrameW = chip_pkg::FrameW;
  localparam int AddrW  = chip_pkg::AddrW;
  localparam int DataW  = chip_pkg::DataW;

  logic [2:0]        sync1_q, sync2_q; // {tdi, tms, tck}
  logic [1:0]        prev_q;           // {tms, tck}, for edge detect
  logic              tck_rise, tms_fall, shift_en, issue;
  logic [FrameW-1:0] frame_q, cmd_q;
  logic [DataW-1:0]  tdo_q;
  logic              req_q, rd_pend_q;

  ////////////////////////////////////////////////////////////////////////////
  // Pin synchronizer and edge detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= {jtag_tdi_i, jtag_tms_i, jtag_tck_i};
      sync2_q <= sync1_q;
      prev_q  <= sync2_q[1:0];
    end
  end

  assign tck_rise = sync2_q[0] & ~prev_q[0];
  assign tms_fall = ~sync2_q[1] & prev_q[1]; // End of frame
  assign shift_en = tck_rise & sync2_q[1];
  assign issue    = tms_fall & ~req_q & ~rd_pend_q;

  ////////////////////////////////////////////////////////////////////////////
  // Frame capture and bus access
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (shift_en) frame_q <= {frame_q[FrameW-2:0], sync2_q[2]};
    if (issue)    cmd_q   <= frame_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q     <= 1'b0;
      rd_pend_q <= 1'b0;
      tdo_q     <= '0;
    end else begin
      if (issue) begin
        req_q <= 1'b1;
      end else if (req_q && bus.gnt) begin
        req_q     <= 1'b0;
        rd_pend_q <= ~cmd_q[FrameW-1]; // Reads wait for rvalid
      end

      if (bus.rvalid) begin
        rd_pend_q <= 1'b0;
        tdo_q     <= bus.rdata;
      end else if (shift_en) begin
        tdo_q <= tdo_q >> 1; // LSB first out
      end
    end
  end

  assign bus.req    = req_q;
  assign bus.we     = cmd_q[FrameW-1];
  assign bus.addr   = cmd_q[FrameW-2 -: AddrW];
  assign bus.wdata  = cmd_q[DataW-1:0];
  assign jtag_tdo_o = tdo_q[0];

endmodule

//--- jtag_mux.sv
// JTAG overlay between the pad vectors and the core. When the strap pad
// is high the four JTAG pads are taken over; otherwise a plain pass-through.

module jtag_mux #(
  parameter int                NumIOs       = 12,
  parameter int                JtagEnIdx    = 7,
  parameter int                TckIdx       = 8,
  parameter int                TmsIdx       = 9,
  parameter int                TdiIdx       = 10,
  parameter int                TdoIdx       = 11,
  parameter logic [NumIOs-1:0] TieOffValues = '0
) (
  // Pad side
  input  logic [NumIOs-1:0] in_padring_i,
  output logic [NumIOs-1:0] out_padring_o,
  output logic [NumIOs-1:0] oe_padring_o,
  // Core side
  input  logic [NumIOs-1:0] out_core_i,
  input  logic [NumIOs-1:0] oe_core_i,
  output logic [NumIOs-1:0] in_core_o,
  // JTAG side
  output logic              jtag_tck_o,
  output logic              jtag_tms_o,
  output logic              jtag_tdi_o,
  input  logic              jtag_tdo_i
);

  logic jtag_en;

  assign jtag_en = in_padring_i[JtagEnIdx]; // Strap itself always reaches the core

  always_comb begin
    out_padring_o = out_core_i;
    oe_padring_o  = oe_core_i;
    in_core_o     = in_padring_i;
    jtag_tck_o    = 1'b0;
    jtag_tms_o    = 1'b0;
    jtag_tdi_o    = 1'b0;

    if (jtag_en) begin
      jtag_tck_o = in_padring_i[TckIdx];
      jtag_tms_o = in_padring_i[TmsIdx];
      jtag_tdi_o = in_padring_i[TdiIdx];

      // Inputs only on TCK/TMS/TDI
      out_padring_o[TckIdx] = 1'b0;
      out_padring_o[TmsIdx] = 1'b0;
      out_padring_o[TdiIdx] = 1'b0;
      oe_padring_o[TckIdx]  = 1'b0;
      oe_padring_o[TmsIdx]  = 1'b0;
      oe_padring_o[TdiIdx]  = 1'b0;
      out_padring_o[TdoIdx] = jtag_tdo_i;
      oe_padring_o[TdoIdx]  = 1'b1;

      // Core gets idle values instead of the JTAG traffic
      in_core_o[TckIdx] = TieOffValues[TckIdx];
      in_core_o[TmsIdx] = TieOffValues[TmsIdx];
      in_core_o[TdiIdx] = TieOffValues[TdiIdx];
      in_core_o[TdoIdx] = TieOffValues[TdoIdx];
    end
  end

endmodule

//--- reg_bus_if.sv
// Simple strobe-based register bus. Used between each master and the
// arbiter, and between the arbiter and the register file.

interface reg_bus_if #(
  parameter int AddrW = chip_pkg::AddrW,
  parameter int DataW = chip_pkg::DataW
) ();

  logic             req;    // Held until gnt
  logic             we;
  logic [AddrW-1:0] addr;
  logic [DataW-1:0] wdata;
  logic             gnt;    // One-cycle accept pulse
  logic [DataW-1:0] rdata;
  logic             rvalid; // One cycle after a read gnt

  modport master (output req, we, addr, wdata, input gnt, rdata, rvalid);
  modport slave  (input req, we, addr, wdata, output gnt, rdata, rvalid);

endinterface

//--- chip_pkg.sv
// Shared constants for the chip wrapper: pad counts, JTAG pinout,
// register map and bus widths. Referenced by scoped name only.

package chip_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pads
  ////////////////////////////////////////////////////////////////////////////

  localparam int NumMio = 8;               // Muxed GPIO pads
  localparam int NumDio = 4;               // Dedicated pads
  localparam int NumIos = NumMio + NumDio; // mio first, then dio

  localparam int JtagEnIdx = 7;            // Strap pin, mio 7
  localparam int TckIdx    = NumMio + 0;
  localparam int TmsIdx    = NumMio + 1;
  localparam int TdiIdx    = NumMio + 2;
  localparam int TdoIdx    = NumMio + 3;

  // Core sees these on the JTAG pads while the overlay is active.
  // TMS doubles as a chip select that idles high.
  localparam logic [NumIos-1:0] TieOffValues = NumIos'(1) << TmsIdx;

  ////////////////////////////////////////////////////////////////////////////
  // Register bus and map
  ////////////////////////////////////////////////////////////////////////////

  localparam int AddrW  = 3;
  localparam int DataW  = 8;
  localparam int FrameW = 1 + AddrW + DataW; // {we, addr, data}, MSB first

  localparam logic [AddrW-1:0] RegOutLo = AddrW'(0); // mio out
  localparam logic [AddrW-1:0] RegOeLo  = AddrW'(1); // mio oe
  localparam logic [AddrW-1:0] RegOutHi = AddrW'(2); // dio out, bits 3:0
  localparam logic [AddrW-1:0] RegOeHi  = AddrW'(3); // dio oe, bits 3:0
  localparam logic [AddrW-1:0] RegInLo  = AddrW'(4); // mio input snapshot
  localparam logic [AddrW-1:0] RegInHi  = AddrW'(5); // dio input snapshot

  localparam int NumRegs = 6;

endpackage
